// ==== nmr_pkg.sv ====
package nmr_pkg;

	// ========================================
	// widths
	// ========================================

	localparam int ADC_PHYS_WIDTH = 14;	// physical adc code
	localparam int ADC_DATA_WIDTH = 16;	// sample width after sign extension
	localparam int TIMER_WIDTH    = 16;	// pulse and delay lengths
	localparam int COUNT_WIDTH    = 16;	// echo and sample counts

	// ========================================
	// scalar types
	// ========================================

	typedef logic [TIMER_WIDTH-1:0]    timer_t;		// cycles of pulseprog_clk
	typedef logic [COUNT_WIDTH-1:0]    count_t;		// echoes, samples
	typedef logic [ADC_PHYS_WIDTH-1:0] adc_raw_t;	// two's complement adc code
	typedef logic [ADC_DATA_WIDTH-1:0] sample_t;	// sign extended code

	// ========================================
	// structs
	// ========================================

	// cpmg scan description, latched on start
	typedef struct packed {
		timer_t pulse_90;			// 90 deg pulse length
		timer_t delay_nosig;		// dead time after the 90
		timer_t pulse_180;			// refocusing pulse length
		timer_t delay_sig;			// echo delay incl. acquisition
		count_t echoes_per_scan;	// number of 180s
		count_t samples_per_echo;	// window length, <= delay_sig
		logic   phase_cycle;		// phase of the 90 deg pulse
	} seq_params_t;

	// raw adc bus
	typedef struct packed {
		adc_raw_t code;	// data bits
		logic     ovr;	// out of range flag
	} adc_in_t;

	// one buffered sample
	typedef struct packed {
		sample_t data;	// sign extended
		logic    ovr;	// adc overflow at capture
		count_t  echo;	// echo number within the scan, from 0
	} echo_sample_t;

	// sequencer states
	typedef enum logic [2:0] {
		IDLE,		// waiting for start
		P90,		// excitation pulse
		D_NOSIG,	// delay, no acquisition
		P180,		// refocusing pulse
		D_SIG		// delay with echo acquisition
	} seq_state_e;

endpackage

// ==== cpmg_sequencer.sv ====
module cpmg_sequencer (
	input  logic                 pulseprog_clk,
	input  logic                 rst,
	input  logic                 start,			// 1-cycle request
	input  nmr_pkg::seq_params_t params,		// sampled only on accepted start
	output logic                 rf_gate,		// tx gate, replaces rf carrier
	output logic                 rf_phase,		// phase of the current pulse
	output logic                 en_rx,			// receiver on
	output logic                 acq_window,	// adc capture window
	output nmr_pkg::count_t      echo_index,	// current echo number
	output logic                 busy			// scan running
);

	// ========================================
	// state
	// ========================================

	nmr_pkg::seq_state_e  state;		// scan fsm
	nmr_pkg::seq_params_t prm;			// latched copy of params
	nmr_pkg::timer_t      timer;		// cycles left in phase, minus one
	nmr_pkg::count_t      echo_cnt;		// 180s already started
	nmr_pkg::timer_t      sig_elapsed;	// position inside the acq delay, from 1
	logic                 accept;		// start taken this cycle
	logic                 last_echo;	// final echo of the scan

	assign accept    = (state == nmr_pkg::IDLE) && start;	// ignored while busy
	assign last_echo = (echo_cnt == prm.echoes_per_scan - nmr_pkg::count_t'(1));

	// latch the scan parameters, payload only
	always_ff @(posedge pulseprog_clk)
	begin
		if (accept)
		begin
			prm <= params;
		end
	end

	// ========================================
	// scan fsm
	// ========================================

	always_ff @(posedge pulseprog_clk)
	begin
		if (rst)
		begin
			state    <= nmr_pkg::IDLE;
			timer    <= '0;
			echo_cnt <= '0;
		end
		else if (state == nmr_pkg::IDLE)
		begin
			if (start)
			begin
				state    <= nmr_pkg::P90;	// 90 runs from next cycle
				timer    <= params.pulse_90 - nmr_pkg::timer_t'(1);
				echo_cnt <= '0;
			end
		end
		else if (timer != '0)
		begin
			timer <= timer - nmr_pkg::timer_t'(1);	// still inside current phase
		end
		else
		begin
			case (state)
				nmr_pkg::P90:
				begin
					state <= nmr_pkg::D_NOSIG;
					timer <= prm.delay_nosig - nmr_pkg::timer_t'(1);
				end
				nmr_pkg::D_NOSIG:
				begin
					state <= nmr_pkg::P180;	// first echo
					timer <= prm.pulse_180 - nmr_pkg::timer_t'(1);
				end
				nmr_pkg::P180:
				begin
					state <= nmr_pkg::D_SIG;
					timer <= prm.delay_sig - nmr_pkg::timer_t'(1);
				end
				nmr_pkg::D_SIG:
				begin
					if (last_echo)
					begin
						state <= nmr_pkg::IDLE;	// scan done
					end
					else
					begin
						state    <= nmr_pkg::P180;	// next refocusing pulse
						timer    <= prm.pulse_180 - nmr_pkg::timer_t'(1);
						echo_cnt <= echo_cnt + nmr_pkg::count_t'(1);
					end
				end
				default:
				begin
					state <= nmr_pkg::IDLE;
				end
			endcase
		end
	end

	// ========================================
	// outputs from state and timer
	// ========================================

	// timer counts down from delay_sig-1, so this runs 1..delay_sig
	assign sig_elapsed = prm.delay_sig - timer;

	assign rf_gate    = (state == nmr_pkg::P90) || (state == nmr_pkg::P180);
	assign rf_phase   = (state == nmr_pkg::P90) && prm.phase_cycle;	// 180s at phase 0
	assign en_rx      = (state == nmr_pkg::D_SIG);	// whole acq delay
	assign acq_window = en_rx && (sig_elapsed <= prm.samples_per_echo);	// first samples only
	assign echo_index = echo_cnt;
	assign busy       = (state != nmr_pkg::IDLE);

endmodule

// ==== adc_sampler.sv ====
module adc_sampler #(
	parameter int ADC_LATENCY = 5,	// adc pipeline depth, 1..8
	parameter int FIFO_DEPTH  = 16	// initial push credits
) (
	input  logic                  pulseprog_clk,
	input  logic                  rst,
	input  logic                  acq_window,	// from sequencer
	input  nmr_pkg::count_t       echo_index,	// from sequencer
	input  nmr_pkg::adc_in_t      adc_in,		// raw adc bus
	output logic                  push,			// write one entry
	output nmr_pkg::echo_sample_t push_data,
	input  logic                  push_credit,	// one entry freed
	output logic                  lost_sample	// sticky drop flag
);

	localparam int CRED_W = $clog2(FIFO_DEPTH + 1);
	localparam int EXT_W  = nmr_pkg::ADC_DATA_WIDTH - nmr_pkg::ADC_PHYS_WIDTH;

	logic [ADC_LATENCY-1:0] win_dly;					// window delay line
	nmr_pkg::count_t        echo_dly [ADC_LATENCY];		// echo tag delay line
	logic [CRED_W-1:0]      credits;					// free fifo slots we may use
	logic                   capture;					// aligned window cycle
	logic                   take;						// capture with a credit

	// ========================================
	// align window with adc pipeline
	// ========================================

	always_ff @(posedge pulseprog_clk)
	begin
		if (rst)
		begin
			win_dly <= '0;
		end
		else
		begin
			win_dly[0] <= acq_window;
			for (int i = 1; i < ADC_LATENCY; i++)
			begin
				win_dly[i] <= win_dly[i-1];
			end
		end
	end

	always_ff @(posedge pulseprog_clk)
	begin
		echo_dly[0] <= echo_index;	// tag follows the window
		for (int i = 1; i < ADC_LATENCY; i++)
		begin
			echo_dly[i] <= echo_dly[i-1];
		end
	end

	assign capture = win_dly[ADC_LATENCY-1];
	assign take    = capture && (credits != '0);	// no credit, no push

	// ========================================
	// credits, push and loss flag
	// ========================================

	always_ff @(posedge pulseprog_clk)
	begin
		if (rst)
		begin
			credits     <= CRED_W'(FIFO_DEPTH);
			push        <= 1'b0;
			lost_sample <= 1'b0;
		end
		else
		begin
			case ({push_credit, take})
				2'b10:   credits <= credits + CRED_W'(1);	// returned
				2'b01:   credits <= credits - CRED_W'(1);	// spent
				default: credits <= credits;				// none or both
			endcase
			push <= take;
			if (capture && !take)
			begin
				lost_sample <= 1'b1;	// held until reset
			end
		end
	end

	// payload, sign extended
	always_ff @(posedge pulseprog_clk)
	begin
		if (take)
		begin
			push_data.data <= {{EXT_W{adc_in.code[nmr_pkg::ADC_PHYS_WIDTH-1]}}, adc_in.code};
			push_data.ovr  <= adc_in.ovr;
			push_data.echo <= echo_dly[ADC_LATENCY-1];
		end
	end

endmodule

// ==== sample_fifo.sv ====
module sample_fifo #(
	parameter int FIFO_DEPTH = 16	// entries, power of two
) (
	input  logic                  pulseprog_clk,
	input  logic                  rst,
	input  logic                  push,			// never while full, credit guarded
	input  nmr_pkg::echo_sample_t push_data,
	output logic                  push_credit,	// one pulse per pop
	input  logic                  pop,
	output nmr_pkg::echo_sample_t head,			// oldest entry
	output logic                  not_empty
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	nmr_pkg::echo_sample_t mem [FIFO_DEPTH];	// sample storage
	logic [PTR_W-1:0]      wr_ptr;				// wraps at depth
	logic [PTR_W-1:0]      rd_ptr;
	logic [CNT_W-1:0]      count;				// entries held
	logic                  do_pop;				// pop of a valid entry

	assign do_pop    = pop && not_empty;
	assign not_empty = (count != '0);
	assign head      = mem[rd_ptr];	// show-ahead read

	// ========================================
	// storage
	// ========================================

	always_ff @(posedge pulseprog_clk)
	begin
		if (push)
		begin
			mem[wr_ptr] <= push_data;
		end
	end

	// ========================================
	// pointers, count, credit return
	// ========================================

	always_ff @(posedge pulseprog_clk)
	begin
		if (rst)
		begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			push_credit <= 1'b0;
		end
		else
		begin
			if (push)
			begin
				wr_ptr <= wr_ptr + PTR_W'(1);
			end
			if (do_pop)
			begin
				rd_ptr <= rd_ptr + PTR_W'(1);
			end
			count       <= count + CNT_W'(push) - CNT_W'(do_pop);
			push_credit <= do_pop;	// slot freed, hand it back
		end
	end

endmodule

// ==== sample_streamer.sv ====
module sample_streamer #(
	parameter int OUT_CREDITS = 4	// credits held after reset
) (
	input  logic                  pulseprog_clk,
	input  logic                  rst,
	input  logic                  not_empty,	// fifo has data
	input  nmr_pkg::echo_sample_t head,			// fifo head entry
	output logic                  pop,			// take head this cycle
	output logic                  out_valid,	// 1 cycle per sample
	output nmr_pkg::echo_sample_t out_sample,
	input  logic                  out_credit	// 1 credit back per pulse
);

	localparam int CRED_W = $clog2(OUT_CREDITS + 1);

	logic [CRED_W-1:0] credits;	// samples we may still send

	// only pop what can be sent right away
	assign pop = not_empty && (credits != '0);

	// ========================================
	// credit counter and valid
	// ========================================

	always_ff @(posedge pulseprog_clk)
	begin
		if (rst)
		begin
			credits   <= CRED_W'(OUT_CREDITS);
			out_valid <= 1'b0;
		end
		else
		begin
			case ({out_credit, pop})
				2'b10:   credits <= credits + CRED_W'(1);	// credit returned
				2'b01:   credits <= credits - CRED_W'(1);	// credit spent
				default: credits <= credits;
			endcase
			out_valid <= pop;
		end
	end

	// output register, payload
	always_ff @(posedge pulseprog_clk)
	begin
		if (pop)
		begin
			out_sample <= head;	// data, ovr and echo tag
		end
	end

endmodule

// ==== nmr_controller.sv ====
module nmr_controller #(
	parameter int ADC_LATENCY = 5,	// adc pipeline, 1..8
	parameter int FIFO_DEPTH  = 16,	// power of two
	parameter int OUT_CREDITS = 4	// output credits after reset
) (
	input  logic                  pulseprog_clk,
	input  logic                  rst,
	input  nmr_pkg::seq_params_t  params,		// scan description
	input  logic                  start,		// 1-cycle scan request
	input  nmr_pkg::adc_in_t      adc_in,		// new value each cycle
	input  logic                  out_credit,	// returns one output credit
	output logic                  rf_gate,
	output logic                  rf_phase,
	output logic                  en_rx,
	output logic                  en_adc,		// acquisition window
	output logic                  busy,
	output logic                  out_valid,
	output nmr_pkg::echo_sample_t out_sample,
	output logic                  lost_sample	// sticky
);

	// ========================================
	// internal links
	// ========================================

	nmr_pkg::count_t       echo_index;	// sequencer -> sampler
	logic                  push;		// sampler -> fifo
	nmr_pkg::echo_sample_t push_data;
	logic                  push_credit;	// fifo -> sampler
	logic                  pop;			// streamer -> fifo
	nmr_pkg::echo_sample_t head;		// fifo -> streamer
	logic                  not_empty;

	cpmg_sequencer seq_i (
		.pulseprog_clk (pulseprog_clk),
		.rst           (rst),
		.start         (start),
		.params        (params),
		.rf_gate       (rf_gate),
		.rf_phase      (rf_phase),
		.en_rx         (en_rx),
		.acq_window    (en_adc),	// window leaves as adc enable
		.echo_index    (echo_index),
		.busy          (busy)
	);

	adc_sampler #(
		.ADC_LATENCY (ADC_LATENCY),
		.FIFO_DEPTH  (FIFO_DEPTH)
	) sampler_i (
		.pulseprog_clk (pulseprog_clk),
		.rst           (rst),
		.acq_window    (en_adc),
		.echo_index    (echo_index),
		.adc_in        (adc_in),
		.push          (push),
		.push_data     (push_data),
		.push_credit   (push_credit),
		.lost_sample   (lost_sample)
	);

	sample_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) fifo_i (
		.pulseprog_clk (pulseprog_clk),
		.rst           (rst),
		.push          (push),
		.push_data     (push_data),
		.push_credit   (push_credit),
		.pop           (pop),
		.head          (head),
		.not_empty     (not_empty)
	);

	sample_streamer #(
		.OUT_CREDITS (OUT_CREDITS)
	) streamer_i (
		.pulseprog_clk (pulseprog_clk),
		.rst           (rst),
		.not_empty     (not_empty),
		.head          (head),
		.pop           (pop),
		.out_valid     (out_valid),
		.out_sample    (out_sample),
		.out_credit    (out_credit)
	);

endmodule

// ==== nmr_assertions.sv ====
module nmr_assertions #(
	parameter int FIFO_DEPTH = 16
) (
	input logic pulseprog_clk,
	input logic rst,
	input logic rf_gate,
	input logic en_rx,
	input logic en_adc,
	input logic push,
	input logic pop,
	input logic not_empty
);
	timeunit 1ns;
	timeprecision 100ps;

	int occ;	// fifo fill level, seen from outside

	always_ff @(posedge pulseprog_clk)
	begin
		if (rst)
		begin
			occ <= 0;
		end
		else
		begin
			occ <= occ + int'(push) - int'(pop && not_empty);
		end
	end

	// ========================================
	// properties
	// ========================================

	a_push_credit: assert property (@(posedge pulseprog_clk) disable iff (rst)
		push |-> occ < FIFO_DEPTH) else $error("fifo push with no free slot");

	// window sits inside rx and opens together with it
	a_adc_rx: assert property (@(posedge pulseprog_clk) disable iff (rst)
		en_adc |-> en_rx && ($past(en_adc) || $rose(en_rx)))
		else $error("adc window outside the head of receiver enable");

	// rx only opens straight after a refocusing pulse
	a_gate_rx: assert property (@(posedge pulseprog_clk) disable iff (rst)
		!(rf_gate && en_rx) && (!$rose(en_rx) || $past(rf_gate)))
		else $error("rf gate overlaps receiver enable or rx opens without a pulse");

endmodule

// ==== nmr_checker.sv ====
module nmr_checker #(
	parameter int ADC_LATENCY = 5,	// must match the dut
	parameter int OUT_CREDITS = 4
) (
	input  logic                  pulseprog_clk,
	input  logic                  rst,
	input  logic                  start,
	input  nmr_pkg::seq_params_t  params,
	input  nmr_pkg::adc_in_t      adc_in,
	input  logic                  out_credit,
	input  logic                  rf_gate,
	input  logic                  rf_phase,
	input  logic                  en_rx,
	input  logic                  en_adc,
	input  logic                  busy,
	input  logic                  out_valid,
	input  nmr_pkg::echo_sample_t out_sample,
	output int                    errors,		// mismatches so far
	output int                    received,		// out_valid count
	output int                    pending		// samples not yet seen at output
);
	timeunit 1ns;
	timeprecision 100ps;

	// ========================================
	// reference model state
	// ========================================

	int                    ph;			// 0 idle, 1 p90, 2 nosig, 3 p180, 4 sig
	int                    pos;			// cycle inside phase, from 0
	int                    echo;		// current echo
	int                    cyc;			// edges since reset
	int                    credits;		// output credits held
	nmr_pkg::seq_params_t  lp;			// params of the running scan
	int                    due_q[$];	// edge at which the adc word is valid
	int                    tag_q[$];	// echo of that window cycle
	nmr_pkg::echo_sample_t exp_q[$];	// expected output stream

	function automatic int phase_len(int p);
		case (p)
			1:       return int'(lp.pulse_90);
			2:       return int'(lp.delay_nosig);
			3:       return int'(lp.pulse_180);
			default: return int'(lp.delay_sig);
		endcase
	endfunction

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp)
		begin
			errors++;
			$display("ERR %s exp %h got %h at cycle %0d", name, exp, got, cyc);
		end
	endtask

	task automatic check_sample(nmr_pkg::echo_sample_t e);
		if (out_sample.data !== e.data)
		begin
			errors++;
			$display("ERR out_sample.data exp %h got %h", e.data, out_sample.data);
		end
		if (out_sample.ovr !== e.ovr)
		begin
			errors++;
			$display("ERR out_sample.ovr exp %h got %h", e.ovr, out_sample.ovr);
		end
		if (out_sample.echo !== e.echo)
		begin
			errors++;
			$display("ERR out_sample.echo exp %h got %h", e.echo, out_sample.echo);
		end
	endtask

	always @(posedge pulseprog_clk)
	begin
		nmr_pkg::echo_sample_t e;
		logic                  e_adc;
		if (rst)
		begin
			ph       = 0;
			pos      = 0;
			echo     = 0;
			cyc      = 0;
			credits  = OUT_CREDITS;
			errors   = 0;
			received = 0;
			pending  = 0;
			due_q.delete();
			tag_q.delete();
			exp_q.delete();
		end
		else
		begin
			cyc++;
			// control outputs from the schedule
			e_adc = (ph == 4) && (pos < int'(lp.samples_per_echo));	// window head of delay
			check_bit("rf_gate", rf_gate, (ph == 1) || (ph == 3));
			check_bit("rf_phase", rf_phase, (ph == 1) && lp.phase_cycle);
			check_bit("en_rx", en_rx, ph == 4);
			check_bit("en_adc", en_adc, e_adc);
			check_bit("busy", busy, ph != 0);

			// adc word belonging to an earlier window cycle
			if (due_q.size() > 0 && due_q[0] == cyc)
			begin
				e.data = nmr_pkg::sample_t'($signed(adc_in.code));
				e.ovr  = adc_in.ovr;
				e.echo = nmr_pkg::count_t'(tag_q[0]);
				exp_q.push_back(e);
				void'(due_q.pop_front());
				void'(tag_q.pop_front());
			end
			if (e_adc)
			begin
				due_q.push_back(cyc + ADC_LATENCY);	// pipeline delay
				tag_q.push_back(echo);
			end

			// output credits
			if (out_credit)
			begin
				credits++;
			end
			if (out_valid)
			begin
				if (credits == 0)
				begin
					errors++;
					$display("out_valid asserted with no output credit at cycle %0d", cyc);
				end
				else
				begin
					credits--;
				end
				if (exp_q.size() == 0)
				begin
					errors++;
					$display("out_valid with no expected sample left at cycle %0d", cyc);
				end
				else
				begin
					check_sample(exp_q.pop_front());
				end
				received++;
			end
			pending = exp_q.size() + due_q.size();

			// advance the schedule
			if (ph == 0)
			begin
				if (start)
				begin
					lp   = params;	// latched on start only
					ph   = 1;
					pos  = 0;
					echo = 0;
				end
			end
			else
			begin
				pos++;
				if (pos == phase_len(ph))
				begin
					pos = 0;
					if (ph == 4)
					begin
						echo++;
						ph = (echo == int'(lp.echoes_per_scan)) ? 0 : 3;
					end
					else
					begin
						ph++;	// p90 -> nosig -> p180 -> sig
					end
				end
			end
		end
	end

endmodule

// ==== nmr_tb.sv ====
module nmr_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ADC_LATENCY = 5;
	localparam int FIFO_DEPTH  = 16;
	localparam int OUT_CREDITS = 4;
	localparam int NUM_TESTS   = 5;

	logic                  pulseprog_clk;
	logic                  rst;
	nmr_pkg::seq_params_t  params;
	logic                  start;
	nmr_pkg::adc_in_t      adc_in;
	logic                  out_credit;
	logic                  rf_gate;
	logic                  rf_phase;
	logic                  en_rx;
	logic                  en_adc;
	logic                  busy;
	logic                  out_valid;
	nmr_pkg::echo_sample_t out_sample;
	logic                  lost_sample;
	int                    errors;
	int                    received;
	int                    pending;

	nmr_pkg::seq_params_t  tp [NUM_TESTS];	// scan per test
	nmr_pkg::seq_params_t  alt_params;		// sent while busy
	string                 names [NUM_TESTS];
	int                    lfsr = 1;		// seed
	int                    budget = 0;		// watchdog, in cycles
	int                    owed = 0;		// credits not yet returned
	int                    failed = 0;
	bit                    hold = 0;		// withhold out_credit

	always #2 pulseprog_clk = ~pulseprog_clk;

	nmr_controller #(
		.ADC_LATENCY (ADC_LATENCY),
		.FIFO_DEPTH  (FIFO_DEPTH),
		.OUT_CREDITS (OUT_CREDITS)
	) dut_i (.*);

	nmr_checker #(
		.ADC_LATENCY (ADC_LATENCY),
		.OUT_CREDITS (OUT_CREDITS)
	) checker_i (.*);

	bind nmr_controller nmr_assertions #(.FIFO_DEPTH(FIFO_DEPTH)) assert_i (
		.pulseprog_clk (pulseprog_clk),
		.rst           (rst),
		.rf_gate       (rf_gate),
		.en_rx         (en_rx),
		.en_adc        (en_adc),
		.push          (push),
		.pop           (pop),
		.not_empty     (not_empty)
	);

	// galois lfsr, taps 32 22 2 1, one step per bit
	function automatic int rand_bits(int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++)
		begin
			r    = (r << 1) | (lfsr & 1);
			lfsr = (lfsr & 1) ? ((lfsr >>> 1) & 32'h7fffffff) ^ 32'h80200003
			                  : ((lfsr >>> 1) & 32'h7fffffff);
		end
		return r;
	endfunction

	// echoes and spe of 0 mean pick at random
	function automatic nmr_pkg::seq_params_t random_params(int echoes, int spe);
		nmr_pkg::seq_params_t p;
		int                   ds;
		int                   sv;
		int                   ne;
		ds                 = (spe > 0) ? spe + rand_bits(3) : 4 + rand_bits(4) % 12;
		p.pulse_90         = nmr_pkg::timer_t'(1 + rand_bits(3));
		p.delay_nosig      = nmr_pkg::timer_t'(1 + rand_bits(3));
		p.pulse_180        = nmr_pkg::timer_t'(1 + rand_bits(3));
		p.delay_sig        = nmr_pkg::timer_t'(ds);
		sv                 = (spe > 0) ? spe : 1 + rand_bits(4) % ((ds < 8) ? ds : 8);
		p.samples_per_echo = nmr_pkg::count_t'(sv);
		ne                 = (echoes > 0) ? echoes : 1 + rand_bits(2) % 3;
		p.echoes_per_scan  = nmr_pkg::count_t'(ne);
		p.phase_cycle      = 1'(rand_bits(1));
		return p;
	endfunction

	// adc words and credit returns, 1 ns after the edge
	always @(posedge pulseprog_clk)
	begin
		if (out_valid === 1'b1)
		begin
			owed++;
		end
		#1;
		adc_in.code = nmr_pkg::adc_raw_t'(rand_bits(14));
		adc_in.ovr  = 1'(rand_bits(1));
		out_credit  = 1'b0;
		if (!hold && owed > 0 && rand_bits(2) != 0)
		begin
			out_credit = 1'b1;	// random return after output
			owed--;
		end
	end

	task automatic run_test(int t);
		int  err0;
		int  got0;
		int  target;
		int  n;
		bit  loss;
		bit  ok;
		err0 = errors;
		got0 = received;
		loss = (t == NUM_TESTS - 1);	// last test overflows
		hold = (t >= 3);
		@(posedge pulseprog_clk);
		#1;
		params = tp[t];
		start  = 1'b1;
		@(posedge pulseprog_clk);
		#1;
		start = 1'b0;
		if (t == 2)
		begin
			repeat (int'(tp[t].pulse_90) + 1) @(posedge pulseprog_clk);
			#1;
			params = alt_params;	// must be ignored
			start  = 1'b1;
			@(posedge pulseprog_clk);
			#1;
			start = 1'b0;
		end
		while (busy)
		begin
			@(posedge pulseprog_clk);
			#1;
		end
		repeat (ADC_LATENCY + 2) @(posedge pulseprog_clk);	// last captures leave the adc pipe
		#1;
		hold   = 0;
		target = loss ? FIFO_DEPTH + OUT_CREDITS
		              : int'(tp[t].echoes_per_scan) * int'(tp[t].samples_per_echo);
		n = 0;
		while (received - got0 < target && n < 1000)
		begin
			@(posedge pulseprog_clk);
			n++;
		end
		repeat (20) @(posedge pulseprog_clk);	// catch any extra output
		#1;
		ok = 1;
		if (received - got0 != target)
		begin
			ok = 0;
			$display("test %0d delivered %0d samples instead of %0d", t, received - got0, target);
		end
		if (lost_sample !== loss)
		begin
			ok = 0;
			$display("test %0d lost_sample flag is %b, should be %b", t, lost_sample, loss);
		end
		if (!loss && pending != 0)
		begin
			ok = 0;
			$display("test %0d left %0d expected samples unmatched", t, pending);
		end
		if (errors != err0)
		begin
			ok = 0;
		end
		if (!ok)
		begin
			failed++;
		end
		$display("test %0d %s: %s, %0d samples", t, names[t], ok ? "ok" : "FAIL",
			received - got0);
	endtask

	// ========================================
	// main sequence
	// ========================================

	initial
	begin
		pulseprog_clk = 1'b0;
		rst           = 1'b1;
		start         = 1'b0;
		params        = '0;
		adc_in        = '0;
		out_credit    = 1'b0;
		names         = '{"schedule", "sample data", "busy start", "backpressure", "overflow"};
		for (int t = 0; t < 3; t++)
		begin
			tp[t] = random_params(0, 0);
		end
		tp[3]      = random_params(2, 8);	// 16 samples fit
		tp[4]      = random_params(4, 10);	// 40 samples overflow
		alt_params = random_params(0, 0);
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			budget += int'(tp[t].pulse_90) + int'(tp[t].delay_nosig) + 1100
				+ int'(tp[t].echoes_per_scan) * (int'(tp[t].pulse_180) + int'(tp[t].delay_sig));
		end
		repeat (3) @(posedge pulseprog_clk);
		#1;
		rst = 1'b0;
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			run_test(t);
		end
		$display("%0d tests run, %0d failed, %0d check errors", NUM_TESTS, failed, errors);
		if (failed == 0 && errors == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// watchdog
	initial
	begin
		wait (budget > 0);
		#(budget * 4 + 100);
		$display("watchdog expired, the run did not finish within %0d cycles", budget);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== files.f ====
nmr_pkg.sv
cpmg_sequencer.sv
adc_sampler.sv
sample_fifo.sv
sample_streamer.sv
nmr_controller.sv
nmr_assertions.sv
nmr_checker.sv
nmr_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the nmr testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module nmr_tb -f files.f -o nmr_sim

./obj_dir/nmr_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS PASSED" sim.log; then
	exit 0
fi
exit 1
